//--- rtl/rtsim_consts.svh
`ifndef RTSIM_CONSTS_SVH
`define RTSIM_CONSTS_SVH

// Cavity state and sample width
`define RTSIM_DW 18

// ADC word width, top bits of the state
`define RTSIM_ADC_DW 16

// Mechanical eigenmodes, two slots each per frame
`define RTSIM_N_MECH 7

// Electrical time scale, larger means slower cavity
`define RTSIM_MODE_SHIFT 4

// Mechanical decay per update
`define RTSIM_MECH_SHIFT 3

// Scaling of gain times drive
`define RTSIM_GAIN_SHIFT 8

// Detuning product and Lorentz-force square scaling
`define RTSIM_DETUNE_SHIFT 17

// Local bus widths
`define RTSIM_LB_AW 15
`define RTSIM_LB_DW 32

`endif

//--- rtl/rtsim_lb_pkg.sv
`include "rtsim_consts.svh"

package rtsim_lb_pkg;

  // Local bus address and data words
  typedef logic [`RTSIM_LB_AW-1:0] lb_addr_t;
  typedef logic [`RTSIM_LB_DW-1:0] lb_data_t;

  // Register select, decoded from the bus address
  // Gain registers occupy REG_MECH_GAIN up to REG_MECH_GAIN + modes - 1
  typedef enum logic [3:0] {
    REG_CTRL        = 4'd0,
    REG_BEAM_PERIOD = 4'd1,
    REG_BEAM_CHARGE = 4'd2,
    REG_MECH_GAIN   = 4'd8,
    REG_NONE        = 4'd15
  } lb_reg_e;

  // Beam interval in iq strobes
  typedef logic [11:0] beam_period_t;

  // Per-mode coupling gain
  typedef logic signed [11:0] mech_gain_t;

endpackage

//--- rtl/rtsim_dsp_pkg.sv
`include "rtsim_consts.svh"

package rtsim_dsp_pkg;

  // Signal samples
  typedef logic signed [`RTSIM_DW-1:0] sample_t;
  typedef logic signed [`RTSIM_DW+1:0] wide_sample_t;
  typedef logic signed [`RTSIM_ADC_DW-1:0] adc_t;

  // Status bits, caller latches
  typedef logic [7:0] clips_t;

  // Mechanical slot sequencing
  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_MUL,
    SLOT_ACC
  } mech_slot_e;

  // Saturation limits
  localparam int SAT_W = 40;
  localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(`RTSIM_DW-1){1'b1}}});
  localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(`RTSIM_DW-1){1'b0}}});
  localparam adc_t ADC_MAX = adc_t'({1'b0, {(`RTSIM_ADC_DW-1){1'b1}}});
  localparam adc_t ADC_MIN = adc_t'({1'b1, {(`RTSIM_ADC_DW-1){1'b0}}});

  // True when a wide value is representable as a sample
  function automatic logic fits_sample(input logic signed [SAT_W-1:0] x);
    return (x <= SAMPLE_MAX) && (x >= SAMPLE_MIN);
  endfunction

  // Clamp a wide value into sample range
  function automatic sample_t sat_sample(input logic signed [SAT_W-1:0] x);
    if (x > SAMPLE_MAX) begin
      return SAMPLE_MAX;
    end
    if (x < SAMPLE_MIN) begin
      return SAMPLE_MIN;
    end
    return sample_t'(x);
  endfunction

  // Clamp a wide value into ADC range
  function automatic adc_t sat_adc(input logic signed [SAT_W-1:0] x);
    if (x > ADC_MAX) begin
      return ADC_MAX;
    end
    if (x < ADC_MIN) begin
      return ADC_MIN;
    end
    return adc_t'(x);
  endfunction

endpackage

//--- rtl/rtsim_cfg_if.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

interface rtsim_cfg_if import rtsim_lb_pkg::*, rtsim_dsp_pkg::*; ();

  // Control bits from REG_CTRL
  logic beam_en;
  logic mech_en;

  // Beam generator settings
  beam_period_t beam_period;
  sample_t beam_charge;

  // One coupling gain per mechanical mode
  mech_gain_t mech_gain [`RTSIM_N_MECH];

  // Register decoder owns every field
  modport ctrl (output beam_en, mech_en, beam_period, beam_charge, mech_gain);

  // Beam timing side
  modport beam (input beam_en, beam_period, beam_charge);

  // Mechanical resonator side
  modport mech (input mech_en, mech_gain);

endinterface

//--- rtl/lb_decode.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

module lb_decode import rtsim_lb_pkg::*, rtsim_dsp_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  lb_addr_t lb_addr,
  input  lb_data_t lb_data,
  input  logic     lb_write,
  rtsim_cfg_if.ctrl cfg
);

  localparam int GW = $clog2(`RTSIM_N_MECH);
  localparam lb_addr_t GAIN_BASE = lb_addr_t'(REG_MECH_GAIN);
  localparam lb_addr_t GAIN_LAST = lb_addr_t'(REG_MECH_GAIN) + lb_addr_t'(`RTSIM_N_MECH - 1);

  lb_reg_e reg_sel;
  logic [GW-1:0] gain_idx;

  // Full address compare, aliases fall to REG_NONE
  always_comb begin
    reg_sel = REG_NONE;
    if (lb_addr == lb_addr_t'(REG_CTRL)) begin
      reg_sel = REG_CTRL;
    end else if (lb_addr == lb_addr_t'(REG_BEAM_PERIOD)) begin
      reg_sel = REG_BEAM_PERIOD;
    end else if (lb_addr == lb_addr_t'(REG_BEAM_CHARGE)) begin
      reg_sel = REG_BEAM_CHARGE;
    end else if (lb_addr inside {[GAIN_BASE:GAIN_LAST]}) begin
      reg_sel = REG_MECH_GAIN;
    end
  end

  // Mode number is the offset from the first gain register
  assign gain_idx = GW'(lb_addr - GAIN_BASE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg.beam_en     <= 1'b0;
      cfg.mech_en     <= 1'b0;
      cfg.beam_period <= '0;
      cfg.beam_charge <= '0;
      for (int i = 0; i < `RTSIM_N_MECH; i++) begin
        cfg.mech_gain[i] <= '0;
      end
    end else if (lb_write) begin
      case (reg_sel)
        REG_CTRL: begin
          cfg.beam_en <= lb_data[0];
          cfg.mech_en <= lb_data[1];
        end
        REG_BEAM_PERIOD: cfg.beam_period <= beam_period_t'(lb_data);
        // Charge is a full-width signed sample
        REG_BEAM_CHARGE: cfg.beam_charge <= sample_t'(lb_data);
        REG_MECH_GAIN:   cfg.mech_gain[gain_idx] <= mech_gain_t'(lb_data);
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/beam_timing.sv
`timescale 1ns/1ps

module beam_timing import rtsim_lb_pkg::*, rtsim_dsp_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    iq,
  rtsim_cfg_if.beam cfg,
  output sample_t beam_pulse
);

  beam_period_t strobe_cnt;
  logic last_strobe;
  logic fire;

  // Last strobe of the period, a zero period gives 4096 strobes
  assign last_strobe = (strobe_cnt == beam_period_t'(cfg.beam_period - 1'b1));
  assign fire = iq && cfg.beam_en && last_strobe;

  // Charge leaves the cavity on exactly one strobe per period
  assign beam_pulse = fire ? cfg.beam_charge : '0;

  // Strobe counter, held at zero while the beam is off
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      strobe_cnt <= '0;
    end else if (!cfg.beam_en) begin
      strobe_cnt <= '0;
    end else if (iq) begin
      if (last_strobe) begin
        strobe_cnt <= '0;
      end else begin
        strobe_cnt <= strobe_cnt + 1'b1;
      end
    end
  end

endmodule

//--- rtl/cav_elec.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

module cav_elec import rtsim_dsp_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    iq,
  input  sample_t drive,
  input  sample_t beam_pulse,
  input  sample_t mech_x,
  output adc_t    a_field,
  output adc_t    a_forward,
  output adc_t    a_reflect,
  output sample_t cav_eig_drive
);

  // Headroom for drive minus beam minus detuning minus field
  localparam int WW = `RTSIM_DW + 4;
  localparam int PW = 2 * `RTSIM_DW;
  localparam int ADC_LSB = `RTSIM_DW - `RTSIM_ADC_DW;

  sample_t field;
  logic signed [PW-1:0] det_prod;
  logic signed [PW-1:0] field_sq;
  logic signed [WW-1:0] detune;
  logic signed [WW-1:0] eff_drive;
  logic signed [WW-1:0] field_err;
  logic signed [WW-1:0] field_step;
  logic signed [WW-1:0] field_next;
  adc_t fwd_top;
  adc_t fld_top;
  logic signed [`RTSIM_ADC_DW:0] refl_diff;

  // Displacement pulls the cavity off resonance
  assign det_prod = mech_x * field;
  assign detune = WW'(det_prod >>> `RTSIM_DETUNE_SHIFT);

  // First-order step toward the effective drive
  assign eff_drive = drive - beam_pulse - detune;
  assign field_err = eff_drive - field;
  assign field_step = field_err >>> `RTSIM_MODE_SHIFT;
  assign field_next = field + field_step;

  // ADC words take the top bits
  assign fwd_top = adc_t'(drive[`RTSIM_DW-1:ADC_LSB]);
  assign fld_top = adc_t'(field[`RTSIM_DW-1:ADC_LSB]);
  assign refl_diff = fwd_top - fld_top;

  // Lorentz force goes with field squared
  assign field_sq = field * field;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      field         <= '0;
      a_field       <= '0;
      a_forward     <= '0;
      a_reflect     <= '0;
      cav_eig_drive <= '0;
    end else begin
      // State only advances on sample strobes
      if (iq) begin
        field <= sat_sample(field_next);
      end
      a_field       <= fld_top;
      a_forward     <= fwd_top;
      a_reflect     <= sat_adc(refl_diff);
      // Full-scale negative field squares to one past max
      cav_eig_drive <= sat_sample(field_sq >>> `RTSIM_DETUNE_SHIFT);
    end
  end

endmodule

//--- rtl/mech_modes.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

module mech_modes import rtsim_lb_pkg::*, rtsim_dsp_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  sample_t cav_eig_drive,
  input  sample_t piezo,
  rtsim_cfg_if.mech cfg,
  output sample_t mech_x,
  output clips_t  clips
);

  localparam int N_SLOT = 2 * `RTSIM_N_MECH;
  localparam int SLOT_W = $clog2(N_SLOT);
  localparam int PW = $bits(mech_gain_t) + `RTSIM_DW;
  localparam int UW = PW + 2;
  localparam int XW = `RTSIM_DW + $clog2(`RTSIM_N_MECH);

  // Drive summing pipeline
  wide_sample_t sum_eig;
  sample_t eig_drive0;
  sample_t eig_drive;
  logic edrive_clip;

  // Slot sequencing
  logic [SLOT_W-1:0] slot_cnt;
  logic [SLOT_W-2:0] mode_idx;
  logic frame_end;
  mech_slot_e slot;

  // Mode update datapath
  sample_t mode_state [`RTSIM_N_MECH];
  sample_t state_cur;
  logic signed [PW-1:0] prod;
  logic signed [UW-1:0] upd;
  sample_t state_new;
  logic res_ovf;
  logic res_clip;
  logic signed [XW-1:0] x_acc;

  // Lorentz plus piezo, one bit of headroom each way
  assign sum_eig = cav_eig_drive + piezo;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      eig_drive0  <= '0;
      eig_drive   <= '0;
      edrive_clip <= 1'b0;
    end else begin
      eig_drive0  <= sat_sample(sum_eig);
      eig_drive   <= eig_drive0;
      edrive_clip <= !fits_sample(sum_eig);
    end
  end

  // Free-running frame counter, two slots per mode
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_cnt <= '0;
    end else if (frame_end) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  assign frame_end = (slot_cnt == SLOT_W'(N_SLOT - 1));
  assign mode_idx = slot_cnt[SLOT_W-1:1];

  // Even slot multiplies, odd slot accumulates
  always_comb begin
    if (!cfg.mech_en) begin
      slot = SLOT_IDLE;
    end else if (slot_cnt[0]) begin
      slot = SLOT_ACC;
    end else begin
      slot = SLOT_MUL;
    end
  end

  // Resonator step: gain times drive in, a fraction of itself out
  assign state_cur = mode_state[mode_idx];
  assign upd = state_cur + (prod >>> `RTSIM_GAIN_SHIFT) - (state_cur >>> `RTSIM_MECH_SHIFT);
  assign state_new = sat_sample(upd);
  assign res_ovf = !fits_sample(upd);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod     <= '0;
      res_clip <= 1'b0;
      x_acc    <= '0;
      mech_x   <= '0;
      for (int i = 0; i < `RTSIM_N_MECH; i++) begin
        mode_state[i] <= '0;
      end
    end else begin
      res_clip <= 1'b0;
      case (slot)
        SLOT_MUL: prod <= cfg.mech_gain[mode_idx] * eig_drive;
        SLOT_ACC: begin
          mode_state[mode_idx] <= state_new;
          res_clip <= res_ovf;
          // Displacement is the sum over all modes
          if (frame_end) begin
            mech_x <= sat_sample(x_acc + state_new);
            x_acc  <= '0;
          end else begin
            x_acc <= x_acc + state_new;
          end
        end
        default: begin
          // Feedback off, modes hold and no displacement
          x_acc  <= '0;
          mech_x <= '0;
        end
      endcase
    end
  end

  // Upper status bits are reserved
  always_comb begin
    clips = '0;
    clips[0] = res_clip;
    clips[1] = edrive_clip;
  end

endmodule

//--- rtl/rtsim.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

module rtsim import rtsim_dsp_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  // Sample strobe
  input  logic                            iq,
  // Forward drive, not counting beam
  input  logic signed [`RTSIM_DW-1:0]     drive,
  input  logic signed [`RTSIM_DW-1:0]     piezo,
  // Local bus, a one-cycle lb_write causes a write
  input  logic [`RTSIM_LB_DW-1:0]         lb_data,
  input  logic [`RTSIM_LB_AW-1:0]         lb_addr,
  input  logic                            lb_write,
  // ADC outputs
  output logic signed [`RTSIM_ADC_DW-1:0] a_field,
  output logic signed [`RTSIM_ADC_DW-1:0] a_forward,
  output logic signed [`RTSIM_ADC_DW-1:0] a_reflect,
  // Status, caller latches
  output logic [7:0]                      clips
);

  sample_t beam_pulse;
  sample_t cav_eig_drive;
  sample_t mech_x;

  rtsim_cfg_if cfg_bus ();

  lb_decode u_lb_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .lb_addr  (lb_addr),
    .lb_data  (lb_data),
    .lb_write (lb_write),
    .cfg      (cfg_bus.ctrl)
  );

  // Beam loading on iq strobes
  beam_timing u_beam_timing (
    .clk        (clk),
    .arst_n     (arst_n),
    .iq         (iq),
    .cfg        (cfg_bus.beam),
    .beam_pulse (beam_pulse)
  );

  cav_elec u_cav_elec (
    .clk           (clk),
    .arst_n        (arst_n),
    .iq            (iq),
    .drive         (drive),
    .beam_pulse    (beam_pulse),
    .mech_x        (mech_x),
    .a_field       (a_field),
    .a_forward     (a_forward),
    .a_reflect     (a_reflect),
    .cav_eig_drive (cav_eig_drive)
  );

  // Mechanical loop closes back through mech_x
  mech_modes u_mech_modes (
    .clk           (clk),
    .arst_n        (arst_n),
    .cav_eig_drive (cav_eig_drive),
    .piezo         (piezo),
    .cfg           (cfg_bus.mech),
    .mech_x        (mech_x),
    .clips         (clips)
  );

endmodule

//--- bench/rtsim_assertions.sv
`timescale 1ns/1ps

module rtsim_assertions import rtsim_dsp_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    iq,
  input sample_t beam_pulse,
  input adc_t    a_field,
  input adc_t    a_forward,
  input adc_t    a_reflect,
  input clips_t  clips
);

  // Beam charge only leaves on a sample strobe
  beam_on_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    (beam_pulse != '0) |-> iq)
    else $error("beam_pulse nonzero without iq");

  // Reserved status bits
  clips_reserved: assert property (@(posedge clk) disable iff (!arst_n)
    clips[7:2] == '0)
    else $error("reserved clips bits set");

  // First cycle out of reset still shows the reset values
  reset_exit_zero: assert property (@(posedge clk)
    $rose(arst_n) |-> (a_field == '0 && a_forward == '0 && a_reflect == '0 && clips == '0))
    else $error("outputs not zero after reset");

endmodule

bind rtsim rtsim_assertions u_rtsim_assertions (
  .clk        (clk),
  .arst_n     (arst_n),
  .iq         (iq),
  .beam_pulse (beam_pulse),
  .a_field    (a_field),
  .a_forward  (a_forward),
  .a_reflect  (a_reflect),
  .clips      (clips)
);

//--- bench/rtsim_tb.sv
`timescale 1ns/1ps
`include "rtsim_consts.svh"

module rtsim_tb import rtsim_lb_pkg::*, rtsim_dsp_pkg::*; ();

  localparam logic [31:0] SEED = 32'h28b1_0e04;
  localparam int ADC_LSB = `RTSIM_DW - `RTSIM_ADC_DW;
  localparam longint S_MAX = (longint'(1) << (`RTSIM_DW - 1)) - 1;
  localparam longint S_MIN = -(longint'(1) << (`RTSIM_DW - 1));
  localparam longint A_MAX = (longint'(1) << (`RTSIM_ADC_DW - 1)) - 1;
  localparam longint A_MIN = -(longint'(1) << (`RTSIM_ADC_DW - 1));
  // Test lengths in cycles
  localparam int T1_LEN = 4;
  localparam int T2_LEN = 300;
  localparam int T3_LEN = 300;
  localparam int T4_LEN = 400;
  localparam int T5_LEN = 250 + 40 + 40 + 20;
  localparam int N_WRITES = 9;
  localparam int TIMEOUT_CYCLES = 5 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN
                                  + 2 * N_WRITES + 200;

  logic clk;
  logic arst_n;
  logic iq;
  sample_t drive;
  sample_t piezo;
  lb_data_t lb_data;
  lb_addr_t lb_addr;
  logic lb_write;
  adc_t a_field;
  adc_t a_forward;
  adc_t a_reflect;
  clips_t clips;

  // Reference state
  sample_t m_field;
  sample_t m_eig;
  sample_t m_charge;
  sample_t beam_now;
  beam_period_t m_period;
  beam_period_t m_cnt;
  logic m_beam_en;
  logic m_clip;
  logic fire_now;
  adc_t exp_field;
  adc_t exp_fwd;
  adc_t exp_refl;
  int n_pulses = 0;
  int n_clip_cycles = 0;
  int n_checks = 0;
  int n_errors = 0;
  int cycle_cnt = 0;
  int err_start;

  rtsim dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .iq        (iq),
    .drive     (drive),
    .piezo     (piezo),
    .lb_data   (lb_data),
    .lb_addr   (lb_addr),
    .lb_write  (lb_write),
    .a_field   (a_field),
    .a_forward (a_forward),
    .a_reflect (a_reflect),
    .clips     (clips)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic longint clamp(input longint x, input longint lo, input longint hi);
    if (x > hi) begin
      return hi;
    end
    if (x < lo) begin
      return lo;
    end
    return x;
  endfunction

  // Lorentz drive from the scaled square of the field
  function automatic sample_t lorentz_drive(input sample_t f);
    longint sq;
    sq = longint'(f) * longint'(f);
    return sample_t'(clamp(sq >>> `RTSIM_DETUNE_SHIFT, S_MIN, S_MAX));
  endfunction

  // One clock of the electrical cavity with no detuning
  function automatic void ref_cav_step(input logic strobe, input sample_t drv,
                                       input sample_t beam, inout sample_t fld,
                                       output adc_t e_field, output adc_t e_fwd,
                                       output adc_t e_refl);
    longint step;
    e_field = adc_t'(fld >>> ADC_LSB);
    e_fwd = adc_t'(drv >>> ADC_LSB);
    e_refl = adc_t'(clamp(longint'(e_fwd) - longint'(e_field), A_MIN, A_MAX));
    if (strobe) begin
      step = (longint'(drv) - beam - fld) >>> `RTSIM_MODE_SHIFT;
      fld = sample_t'(clamp(longint'(fld) + step, S_MIN, S_MAX));
    end
  endfunction

  task automatic check_adc(input string what, input adc_t got, input adc_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_clips(input clips_t got, input clips_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t ns: clips is %b, expected %b", $time, got, exp);
    end
  endtask

  // Model advances on the same edge as the DUT registers
  always @(posedge clk) begin
    if (!arst_n) begin
      m_field = '0;
      m_eig = '0;
      m_charge = '0;
      m_period = '0;
      m_cnt = '0;
      m_beam_en = 1'b0;
      m_clip = 1'b0;
      exp_field = '0;
      exp_fwd = '0;
      exp_refl = '0;
    end else begin
      fire_now = iq && m_beam_en && (m_cnt == beam_period_t'(m_period - 1'b1));
      beam_now = fire_now ? m_charge : '0;
      if (!m_beam_en) begin
        m_cnt = '0;
      end else if (iq) begin
        m_cnt = fire_now ? '0 : m_cnt + 1'b1;
      end
      // Drive sum overflow while zero gains keep the modes quiet
      m_clip = (longint'(m_eig) + piezo > S_MAX) || (longint'(m_eig) + piezo < S_MIN);
      m_eig = lorentz_drive(m_field);
      ref_cav_step(iq, drive, beam_now, m_field, exp_field, exp_fwd, exp_refl);
      // Register writes land after this edge
      if (lb_write) begin
        if (lb_addr == lb_addr_t'(0)) begin
          m_beam_en = lb_data[0];
        end else if (lb_addr == lb_addr_t'(1)) begin
          m_period = beam_period_t'(lb_data);
        end else if (lb_addr == lb_addr_t'(2)) begin
          m_charge = sample_t'(lb_data);
        end
      end
    end
  end

  // Falling-edge compare against the model
  always @(negedge clk) begin
    if (arst_n) begin
      check_adc("a_field", a_field, exp_field);
      check_adc("a_forward", a_forward, exp_fwd);
      check_adc("a_reflect", a_reflect, exp_refl);
      check_clips(clips, {6'b0, m_clip, 1'b0});
      // Beam pulses and drive clips as the DUT shows them
      if (dut_i.beam_pulse != '0) begin
        n_pulses++;
      end
      if (clips[1]) begin
        n_clip_cycles++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
    @(posedge clk);
    lb_addr <= addr;
    lb_data <= data;
    lb_write <= 1'b1;
    @(posedge clk);
    lb_write <= 1'b0;
  endtask

  // Random iq with iq_pct percent density
  // New random drive every hold cycles and none when hold is 0
  task automatic run_stimulus(input int cycles, input int iq_pct, input int hold);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      if (hold > 0 && i % hold == 0) begin
        drive <= sample_t'($urandom);
      end
      iq <= ($urandom % 100) < iq_pct;
    end
  endtask

  task automatic report_test(input int num, input string name, input int start);
    $display("test %0d %s: %0d errors", num, name, n_errors - start);
  endtask

  initial begin
    arst_n = 1'b0;
    iq = 1'b0;
    drive = '0;
    piezo = '0;
    lb_data = '0;
    lb_addr = '0;
    lb_write = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    err_start = n_errors;
    for (int i = 0; i < T1_LEN; i++) begin
      @(negedge clk);
      check_adc("a_field", a_field, '0);
      check_adc("a_forward", a_forward, '0);
      check_adc("a_reflect", a_reflect, '0);
      check_clips(clips, '0);
    end
    report_test(1, "reset state", err_start);

    err_start = n_errors;
    run_stimulus(T2_LEN, 100, 32);
    report_test(2, "open loop", err_start);

    err_start = n_errors;
    run_stimulus(T3_LEN, 50, 40);
    report_test(3, "random iq", err_start);

    // Beam every 5 strobes
    err_start = n_errors;
    @(posedge clk);
    drive <= 18'sd60000;
    bus_write(lb_addr_t'(1), 32'd5);
    bus_write(lb_addr_t'(2), 32'd3000);
    bus_write(lb_addr_t'(0), 32'd1);
    run_stimulus(T4_LEN, 70, 0);
    if (n_pulses == 0) begin
      n_errors++;
      $display("Test 4 never produced a beam pulse");
    end
    bus_write(lb_addr_t'(0), 32'd0);
    report_test(4, "beam pulses", err_start);

    // Mech feedback on with zero gains
    // Strong field first and full-scale piezo after it
    err_start = n_errors;
    bus_write(lb_addr_t'(0), 32'd2);
    @(posedge clk);
    drive <= sample_t'(S_MAX);
    iq <= 1'b1;
    run_stimulus(250, 100, 0);
    @(posedge clk);
    piezo <= sample_t'(S_MAX);
    run_stimulus(40, 100, 0);
    @(posedge clk);
    piezo <= '0;
    run_stimulus(40, 100, 0);
    // Aliases and holes in the map
    bus_write(lb_addr_t'(3), '1);
    bus_write(lb_addr_t'(15), '1);
    bus_write(lb_addr_t'(15'h4000), '1);
    bus_write(lb_addr_t'(15'h4008), 32'h7ff);
    run_stimulus(20, 100, 0);
    if (n_clip_cycles == 0) begin
      n_errors++;
      $display("Test 5 never saw the drive clip bit set");
    end
    report_test(5, "drive clip", err_start);

    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+rtl
rtl/rtsim_lb_pkg.sv
rtl/rtsim_dsp_pkg.sv
rtl/rtsim_cfg_if.sv
rtl/lb_decode.sv
rtl/beam_timing.sv
rtl/cav_elec.sv
rtl/mech_modes.sv
rtl/rtsim.sv
bench/rtsim_assertions.sv
bench/rtsim_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rtsim testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module rtsim_tb -Mdir obj_dir -o rtsim_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/rtsim_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
